// ==== color_output.sv ====
/* colour stage */

module color_output (
	input  logic                CLK,
	input  logic                RESET_L,
	input  logic                data_valid,
	input  draw_pkg::fade_t     fade_q,
	input  draw_pkg::rom_word_t rom_data,
	output draw_pkg::color4_t   vga_r,
	output draw_pkg::color4_t   vga_g,
	output draw_pkg::color4_t   vga_b
);
	import draw_pkg::*;

	color4_t red_raw;
	color4_t grn_raw;
	color4_t blu_raw;

	assign red_raw = rom_data[3:0];
	assign grn_raw = rom_data[7:4];
	assign blu_raw = rom_data[11:8]; // top nibble ignored

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end
		else if (data_valid) begin
			// dim by shifting every channel
			vga_r <= red_raw >> fade_q;
			vga_g <= grn_raw >> fade_q;
			vga_b <= blu_raw >> fade_q;
		end
	end

endmodule

// ==== draw_macros.svh ====
/* score screen geometry and sprite ROM map */

`ifndef DRAW_MACROS_SVH
`define DRAW_MACROS_SVH

// judgement label sprite, stored column by column
`define SIGN_W 10'd24
`define SIGN_H 10'd64

// counter digit glyphs, ten of them from ROM word 0
`define DIGIT_W 10'd20
`define DIGIT_H 10'd20
`define DIGIT_SIZE 15'd480

// label origins, all on one row
`define PERFECT_X 10'd396
`define GREAT_X 10'd356
`define GOOD_X 10'd316
`define BAD_X 10'd276
`define MISS_X 10'd236
`define LABEL_Y 10'd453

// current judgement box
`define CUR_X 10'd356
`define CUR_Y 10'd123

// combo digits run down from here
`define COMBO_X 10'd396
`define COMBO_Y 10'd98

// counter digit rows under each label
`define DIGIT_Y0 10'd527 // label row + SIGN_H + 10
`define DIGIT_PITCH 10'd23

// lanes and the key buttons to their right
`define LANE_Y0 10'd200
`define LANE_H 10'd60
`define LANE_CNT 4
`define BUTTON_X 10'd420
`define BUTTON_W 10'd60 // square button sprite

/*
 * sprite ROM bases
 * digits sit at 0, the lane note sprites between 12480 and 19080 are unused here
 */
`define BASE_PERFECT 15'd4800
`define BASE_GREAT 15'd6336
`define BASE_GOOD 15'd7872
`define BASE_BAD 15'd9408
`define BASE_MISS 15'd10944
`define BASE_DOWN_BUTTON 15'd19080
`define BASE_UP_BUTTON 15'd22680

`endif

// ==== draw_pkg.sv ====
/* shared display types */

package draw_pkg;

	typedef logic [9:0] coord_t; // screen column or row

	typedef logic [14:0] sprite_addr_t;

	// r in [3:0], g in [7:4], b in [11:8], top nibble spare
	typedef logic [15:0] rom_word_t;

	typedef logic [3:0] color4_t;

	typedef logic [1:0] fade_t; // right shift applied to each channel

	// four BCD digits, most significant in [15:12]
	typedef logic [15:0] bcd4_t;

	typedef enum logic [3:0] {
		JUDGE_NONE    = 4'd0,
		JUDGE_PERFECT = 4'd1,
		JUDGE_GREAT   = 4'd2,
		JUDGE_GOOD    = 4'd3,
		JUDGE_BAD     = 4'd4,
		JUDGE_MISS    = 4'd5
	} judgement_t;

endpackage

// ==== draw_props.sv ====
/* pixel fetch assertions */

module draw_props (
	input logic       CLK,
	input logic       RESET_L,
	input logic       pixel_req,
	input logic       rom_en,
	input logic       data_valid,
	input logic [1:0] phase
);
	timeunit 1ns;
	timeprecision 1ps;

	// read strobe never runs into a third cycle
	rom_en_max_two: assert property (@(posedge CLK) disable iff (!RESET_L)
		rom_en && $past(rom_en) |-> !$past(rom_en, 2))
		else $error("rom_en high for more than two cycles");

	rom_en_min_two: assert property (@(posedge CLK) disable iff (!RESET_L)
		$past(rom_en) && !rom_en |-> $past(rom_en, 2))
		else $error("rom_en high for less than two cycles");

	// hand-over right after the read
	valid_after_read: assert property (@(posedge CLK) disable iff (!RESET_L)
		$past(rom_en) && !rom_en |-> data_valid)
		else $error("data_valid missing after rom_en dropped");

	valid_only_after_read: assert property (@(posedge CLK) disable iff (!RESET_L)
		data_valid |-> $past(rom_en) && !rom_en)
		else $error("data_valid without a finished ROM read");

	no_req_while_busy: assert property (@(posedge CLK) disable iff (!RESET_L)
		pixel_req |-> phase == 2'd0)
		else $error("pixel request arrived during a fetch");

endmodule

bind pixel_fetch draw_props i_props (
	.CLK(CLK),
	.RESET_L(RESET_L),
	.pixel_req(pixel_req),
	.rom_en(rom_en),
	.data_valid(data_valid),
	.phase(phase)
);

// ==== draw_top.sv ====
/* score display pixel path */

module draw_top (
	input  logic                   CLK,
	input  logic                   RESET_L,
	input  logic                   frame_start,
	input  logic                   pixel_req,
	input  draw_pkg::coord_t       pixel_x,
	input  draw_pkg::coord_t       pixel_y,
	input  logic [3:0]             key_down,
	input  draw_pkg::bcd4_t        perfect_cnt,
	input  draw_pkg::bcd4_t        great_cnt,
	input  draw_pkg::bcd4_t        good_cnt,
	input  draw_pkg::bcd4_t        bad_cnt,
	input  draw_pkg::bcd4_t        miss_cnt,
	input  draw_pkg::bcd4_t        combo_cnt,
	input  draw_pkg::judgement_t   cur_judgement,
	input  draw_pkg::fade_t        cur_fade,
	output draw_pkg::sprite_addr_t rom_addr,
	output logic                   rom_en,
	input  draw_pkg::rom_word_t    rom_data,
	output logic                   vga_reset,
	output draw_pkg::color4_t      vga_r,
	output draw_pkg::color4_t      vga_g,
	output draw_pkg::color4_t      vga_b
);
	import draw_pkg::*;

	sprite_addr_t sprite_addr;
	fade_t pixel_fade;
	fade_t fade_q;
	logic data_valid;

	score_layout_decoder i_decoder (
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.key_down(key_down),
		.perfect_cnt(perfect_cnt),
		.great_cnt(great_cnt),
		.good_cnt(good_cnt),
		.bad_cnt(bad_cnt),
		.miss_cnt(miss_cnt),
		.combo_cnt(combo_cnt),
		.cur_judgement(cur_judgement),
		.cur_fade(cur_fade),
		.sprite_addr(sprite_addr),
		.pixel_fade(pixel_fade)
	);

	pixel_fetch i_fetch (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.frame_start(frame_start),
		.pixel_req(pixel_req),
		.sprite_addr(sprite_addr),
		.pixel_fade(pixel_fade),
		.rom_addr(rom_addr),
		.rom_en(rom_en),
		.data_valid(data_valid),
		.fade_q(fade_q),
		.vga_reset(vga_reset)
	);

	color_output i_color (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.data_valid(data_valid),
		.fade_q(fade_q),
		.rom_data(rom_data),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

// ==== flist.f ====
+incdir+.
draw_pkg.sv
score_layout_decoder.sv
pixel_fetch.sv
color_output.sv
draw_top.sv
draw_props.sv
tb_draw_top.sv

// ==== pixel_fetch.sv ====
/* pixel fetch and start-up gate */

module pixel_fetch (
	input  logic                   CLK,
	input  logic                   RESET_L,
	input  logic                   frame_start,
	input  logic                   pixel_req,
	input  draw_pkg::sprite_addr_t sprite_addr,
	input  draw_pkg::fade_t        pixel_fade,
	output draw_pkg::sprite_addr_t rom_addr,
	output logic                   rom_en,
	output logic                   data_valid,
	output draw_pkg::fade_t        fade_q,
	output logic                   vga_reset
);

	logic working;     // set by the first frame start
	logic first_frame; // cleared by the second one
	logic [1:0] phase;
	logic accept;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			working <= 1'b0;
			first_frame <= 1'b1;
		end
		else if (frame_start) begin
			if (!working)
				working <= 1'b1;
			else
				first_frame <= 1'b0;
		end
	end

	assign vga_reset = !working;

	// first frame stays black, busy fetch drops the request
	assign accept = pixel_req && working && !first_frame && phase == 2'd0;

	/*
	 * phase 1 and 2 read the ROM, 3 hands the word over,
	 * then back to idle
	 */
	always_ff @(posedge CLK) begin
		if (!RESET_L)
			phase <= 2'd0;
		else if (accept)
			phase <= 2'd1;
		else if (phase != 2'd0)
			phase <= phase + 2'd1;
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			rom_addr <= sprite_addr;
			fade_q <= pixel_fade;
		end
	end

	assign rom_en = phase == 2'd1 || phase == 2'd2;
	assign data_valid = phase == 2'd3; // second read lands here

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the draw_top testbench, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_draw_top \
	-f flist.f -o sim_draw_top \
	&& ./obj_dir/sim_draw_top > sim.log 2>&1 \
	|| echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && echo "FAIL" && exit 1
echo "PASS"
exit 0

// ==== score_layout_decoder.sv ====
/* score screen layout decoder */

`include "draw_macros.svh"

module score_layout_decoder (
	input  draw_pkg::coord_t       pixel_x,
	input  draw_pkg::coord_t       pixel_y,
	input  logic [3:0]             key_down,
	input  draw_pkg::bcd4_t        perfect_cnt,
	input  draw_pkg::bcd4_t        great_cnt,
	input  draw_pkg::bcd4_t        good_cnt,
	input  draw_pkg::bcd4_t        bad_cnt,
	input  draw_pkg::bcd4_t        miss_cnt,
	input  draw_pkg::bcd4_t        combo_cnt,
	input  draw_pkg::judgement_t   cur_judgement,
	input  draw_pkg::fade_t        cur_fade,
	output draw_pkg::sprite_addr_t sprite_addr,
	output draw_pkg::fade_t        pixel_fade
);
	import draw_pkg::*;

	// perfect..miss order, counters add combo at the end
	localparam coord_t LABEL_X [5] = '{`PERFECT_X, `GREAT_X, `GOOD_X, `BAD_X, `MISS_X};
	localparam sprite_addr_t LABEL_BASE [5] =
		'{`BASE_PERFECT, `BASE_GREAT, `BASE_GOOD, `BASE_BAD, `BASE_MISS};
	localparam coord_t CNT_X [6] =
		'{`PERFECT_X, `GREAT_X, `GOOD_X, `BAD_X, `MISS_X, `COMBO_X};
	localparam coord_t CNT_Y0 [6] =
		'{`DIGIT_Y0, `DIGIT_Y0, `DIGIT_Y0, `DIGIT_Y0, `DIGIT_Y0, `COMBO_Y};

	bcd4_t cnt [6];
	logic lane_hit;
	logic label_hit;
	logic cur_hit;
	logic digit_hit;
	sprite_addr_t lane_addr;
	sprite_addr_t label_addr;
	sprite_addr_t cur_base;
	sprite_addr_t cur_off;
	sprite_addr_t cur_addr;
	sprite_addr_t digit_addr;

	function automatic logic in_box(input coord_t px, input coord_t py,
			input coord_t ox, input coord_t oy, input coord_t w, input coord_t h);
		return px >= ox && px < ox + w && py >= oy && py < oy + h;
	endfunction

	// sprites are stored column major, h words per column
	function automatic sprite_addr_t tile_off(input coord_t px, input coord_t py,
			input coord_t ox, input coord_t oy, input coord_t h);
		sprite_addr_t dx;
		sprite_addr_t dy;
		dx = sprite_addr_t'(px - ox);
		dy = sprite_addr_t'(py - oy);
		return dx * sprite_addr_t'(h) + dy;
	endfunction

	assign cnt = '{perfect_cnt, great_cnt, good_cnt, bad_cnt, miss_cnt, combo_cnt};

	// lane rows win over everything, notes left of the buttons are not drawn
	always_comb begin : lane_scan
		coord_t top;
		top = '0;
		lane_hit = 1'b0;
		lane_addr = '0;
		for (int i = 0; i < `LANE_CNT; i++) begin
			top = coord_t'(`LANE_Y0 + i * `LANE_H);
			if (pixel_y >= top && pixel_y < top + `LANE_H) begin
				lane_hit = 1'b1;
				if (pixel_x >= `BUTTON_X && pixel_x < `BUTTON_X + `BUTTON_W)
					lane_addr = (key_down[i] ? `BASE_DOWN_BUTTON : `BASE_UP_BUTTON) +
						tile_off(pixel_x, pixel_y, `BUTTON_X, top, `LANE_H);
			end
		end
	end

	always_comb begin
		label_hit = 1'b0;
		label_addr = '0;
		for (int i = 0; i < 5; i++) begin
			if (in_box(pixel_x, pixel_y, LABEL_X[i], `LABEL_Y, `SIGN_W, `SIGN_H)) begin
				label_hit = 1'b1;
				label_addr = LABEL_BASE[i] +
					tile_off(pixel_x, pixel_y, LABEL_X[i], `LABEL_Y, `SIGN_H);
			end
		end
	end

	assign cur_hit = in_box(pixel_x, pixel_y, `CUR_X, `CUR_Y, `SIGN_W, `SIGN_H);
	assign cur_off = tile_off(pixel_x, pixel_y, `CUR_X, `CUR_Y, `SIGN_H);

	always_comb begin
		case (cur_judgement)
			JUDGE_PERFECT: cur_base = `BASE_PERFECT;
			JUDGE_GREAT:   cur_base = `BASE_GREAT;
			JUDGE_GOOD:    cur_base = `BASE_GOOD;
			JUDGE_BAD:     cur_base = `BASE_BAD;
			JUDGE_MISS:    cur_base = `BASE_MISS;
			default:       cur_base = '0;
		endcase
	end

	assign cur_addr = (cur_base == '0) ? '0 : cur_base + cur_off; // nothing shown for none

	always_comb begin : digit_scan
		coord_t row_top;
		row_top = '0;
		digit_hit = 1'b0;
		digit_addr = '0;
		for (int c = 0; c < 6; c++) begin
			for (int d = 0; d < 4; d++) begin
				row_top = coord_t'(CNT_Y0[c] + d * `DIGIT_PITCH);
				if (in_box(pixel_x, pixel_y, CNT_X[c], row_top, `DIGIT_W, `DIGIT_H)) begin
					digit_hit = 1'b1;
					// top row shows the most significant digit
					digit_addr = sprite_addr_t'(cnt[c][(3 - d) * 4 +: 4]) * `DIGIT_SIZE +
						tile_off(pixel_x, pixel_y, CNT_X[c], row_top, `DIGIT_H);
				end
			end
		end
	end

	always_comb begin
		sprite_addr = '0;
		pixel_fade = '0;
		if (lane_hit)
			sprite_addr = lane_addr;
		else if (label_hit)
			sprite_addr = label_addr;
		else if (cur_hit) begin
			sprite_addr = cur_addr;
			pixel_fade = cur_fade; // only the current judgement fades
		end
		else if (digit_hit)
			sprite_addr = digit_addr;
	end

endmodule

// ==== tb_draw_top.sv ====
/* draw_top testbench */

`include "draw_macros.svh"

module tb_draw_top;
	timeunit 1ns;
	timeprecision 1ps;
	import draw_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RNG_SEED = 42;
	localparam int MAX_WAIT = 8;
	localparam int FETCH_COUNT = 15 + 24 + 24 + 16 + 3;
	localparam int TEST_CYCLES = 40 + FETCH_COUNT * 5; // about five cycles per fetch
	localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

	localparam int LABEL_X [5] = '{int'(`PERFECT_X), int'(`GREAT_X), int'(`GOOD_X),
		int'(`BAD_X), int'(`MISS_X)};
	localparam int LABEL_BASE [5] = '{int'(`BASE_PERFECT), int'(`BASE_GREAT),
		int'(`BASE_GOOD), int'(`BASE_BAD), int'(`BASE_MISS)};
	localparam int CNT_X [6] = '{int'(`PERFECT_X), int'(`GREAT_X), int'(`GOOD_X),
		int'(`BAD_X), int'(`MISS_X), int'(`COMBO_X)};
	localparam int CNT_Y0 [6] = '{int'(`DIGIT_Y0), int'(`DIGIT_Y0), int'(`DIGIT_Y0),
		int'(`DIGIT_Y0), int'(`DIGIT_Y0), int'(`COMBO_Y)};

	logic CLK;
	logic RESET_L;
	logic frame_start;
	logic pixel_req;
	coord_t pixel_x;
	coord_t pixel_y;
	logic [3:0] key_down;
	bcd4_t perfect_cnt;
	bcd4_t great_cnt;
	bcd4_t good_cnt;
	bcd4_t bad_cnt;
	bcd4_t miss_cnt;
	bcd4_t combo_cnt;
	judgement_t cur_judgement;
	fade_t cur_fade;
	sprite_addr_t rom_addr;
	logic rom_en;
	rom_word_t rom_data;
	logic vga_reset;
	color4_t vga_r;
	color4_t vga_g;
	color4_t vga_b;

	draw_top i_dut (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.frame_start(frame_start),
		.pixel_req(pixel_req),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.key_down(key_down),
		.perfect_cnt(perfect_cnt),
		.great_cnt(great_cnt),
		.good_cnt(good_cnt),
		.bad_cnt(bad_cnt),
		.miss_cnt(miss_cnt),
		.combo_cnt(combo_cnt),
		.cur_judgement(cur_judgement),
		.cur_fade(cur_fade),
		.rom_addr(rom_addr),
		.rom_en(rom_en),
		.rom_data(rom_data),
		.vga_reset(vga_reset),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// sprite ROM, the word echoes the low 12 address bits
	initial begin
		rom_data = '0;
		forever begin
			@(posedge CLK);
			if (rom_en)
				rom_data <= {4'h0, rom_addr[11:0]};
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("Timeout: the tests did not finish in the expected time");
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge CLK);
		#(DRIVE_DELAY);
	endtask

	function automatic int expected_channel(input int addr, input int lsb, input int fade);
		return ((addr >> lsb) & 'hf) >> fade;
	endfunction

	task automatic compare_colour(input int addr, input int fade);
		check_value("vga_r", int'(vga_r), expected_channel(addr, 0, fade));
		check_value("vga_g", int'(vga_g), expected_channel(addr, 4, fade));
		check_value("vga_b", int'(vga_b), expected_channel(addr, 8, fade));
	endtask

	function automatic bcd4_t random_bcd();
		bcd4_t value;
		for (int d = 0; d < 4; d++)
			value[d * 4 +: 4] = 4'($urandom_range(9));
		return value;
	endfunction

	// one request, read in the next two cycles, colour one edge after data_valid
	task automatic fetch_pixel(input int x, input int y, input int exp_addr, input int fade);
		int en_cycles;
		en_cycles = 0;
		pixel_x = coord_t'(x);
		pixel_y = coord_t'(y);
		pixel_req = 1'b1;
		next_cycle();
		pixel_req = 1'b0;
		check_value("rom_en", int'(rom_en), 1); // read starts right after the request
		check_value("rom_addr", int'(rom_addr), exp_addr);
		while (rom_en) begin
			next_cycle();
			en_cycles++;
			if (en_cycles > MAX_WAIT)
				fail_run("rom_en stayed high and never dropped");
		end
		check_value("rom_en cycles", en_cycles, 2);
		next_cycle();
		compare_colour(exp_addr, fade);
	endtask

	task automatic request_ignored(input int x, input int y);
		pixel_x = coord_t'(x);
		pixel_y = coord_t'(y);
		pixel_req = 1'b1;
		next_cycle();
		pixel_req = 1'b0;
		repeat (5) begin
			check_value("rom_en", int'(rom_en), 0);
			compare_colour(0, 0);
			next_cycle();
		end
	endtask

	task automatic pulse_frame_start();
		frame_start = 1'b1;
		next_cycle();
		frame_start = 1'b0;
		next_cycle();
	endtask

	task automatic startup_gate();
		check_value("vga_reset", int'(vga_reset), 1);
		check_value("rom_en", int'(rom_en), 0);
		compare_colour(0, 0);
		RESET_L = 1'b1;
		next_cycle();
		request_ignored(int'(`PERFECT_X), int'(`LABEL_Y)); // gate still closed
		pulse_frame_start();
		check_value("vga_reset", int'(vga_reset), 0);
		request_ignored(int'(`PERFECT_X) + 5, int'(`LABEL_Y) + 5); // first frame stays black
		pulse_frame_start();
		check_value("vga_reset", int'(vga_reset), 0);
	endtask

	task automatic label_sprites();
		int dx;
		int dy;
		for (int i = 0; i < 5; i++) begin
			for (int k = 0; k < 3; k++) begin
				dx = (k == 0) ? 0 : (k == 1) ? int'(`SIGN_W) - 1 : int'($urandom_range(23));
				dy = (k == 0) ? 0 : (k == 1) ? int'(`SIGN_H) - 1 : int'($urandom_range(63));
				fetch_pixel(LABEL_X[i] + dx, int'(`LABEL_Y) + dy,
					LABEL_BASE[i] + dx * int'(`SIGN_H) + dy, 0);
			end
		end
	endtask

	task automatic counter_digits();
		bcd4_t vals [6];
		int dx;
		int dy;
		int digit;
		for (int c = 0; c < 6; c++)
			vals[c] = random_bcd();
		perfect_cnt = vals[0];
		great_cnt = vals[1];
		good_cnt = vals[2];
		bad_cnt = vals[3];
		miss_cnt = vals[4];
		combo_cnt = vals[5];
		for (int c = 0; c < 6; c++) begin
			for (int d = 0; d < 4; d++) begin
				dx = $urandom_range(19);
				dy = $urandom_range(19);
				digit = int'(vals[c][(3 - d) * 4 +: 4]); // top row is the high digit
				fetch_pixel(CNT_X[c] + dx, CNT_Y0[c] + d * int'(`DIGIT_PITCH) + dy,
					digit * int'(`DIGIT_SIZE) + dx * int'(`DIGIT_H) + dy, 0);
			end
		end
	endtask

	task automatic judgement_fade();
		int dx;
		int dy;
		int exp_addr;
		for (int j = 0; j < 6; j++) begin
			for (int f = 0; f < 4; f++) begin
				dx = $urandom_range(23);
				dy = $urandom_range(63);
				cur_judgement = judgement_t'(j);
				cur_fade = fade_t'(f);
				if (j == 0)
					exp_addr = 0;
				else
					exp_addr = LABEL_BASE[j - 1] + dx * int'(`SIGN_H) + dy;
				fetch_pixel(int'(`CUR_X) + dx, int'(`CUR_Y) + dy, exp_addr, f);
			end
		end
		cur_fade = '0;
	endtask

	task automatic key_buttons();
		int dx;
		int dy;
		int base;
		for (int r = 0; r < 4; r++) begin
			key_down = 4'($urandom_range(15));
			for (int lane = 0; lane < 4; lane++) begin
				dx = $urandom_range(59);
				dy = $urandom_range(59);
				base = key_down[lane] ? int'(`BASE_DOWN_BUTTON) : int'(`BASE_UP_BUTTON);
				fetch_pixel(int'(`BUTTON_X) + dx, int'(`LANE_Y0) + lane * int'(`LANE_H) + dy,
					base + dx * int'(`LANE_H) + dy, 0);
			end
		end
	endtask

	task automatic blank_areas();
		fetch_pixel(100, int'(`LANE_Y0) + 30, 0, 0); // lane left of the buttons
		fetch_pixel(600, 10, 0, 0);
		fetch_pixel(5, 700, 0, 0);
	endtask

	initial begin
		void'($urandom(RNG_SEED));
		RESET_L = 1'b0;
		frame_start = 1'b0;
		pixel_req = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		key_down = '0;
		perfect_cnt = '0;
		great_cnt = '0;
		good_cnt = '0;
		bad_cnt = '0;
		miss_cnt = '0;
		combo_cnt = '0;
		cur_judgement = JUDGE_NONE;
		cur_fade = '0;
		repeat (3) @(posedge CLK);
		#(DRIVE_DELAY);
		startup_gate();
		label_sprites();
		counter_digits();
		judgement_fade();
		key_buttons();
		blank_areas();
		$display("All tests passed");
		$finish;
	end

endmodule
